//--- dct_params.svh
`ifndef DCT_PARAMS_SVH
`define DCT_PARAMS_SVH

// datapath widths
`define DCT_DATA_W      16
`define DCT_ADDR_W      8
`define DCT_ACC_W       32      // products and running sums

// transform length
`define DCT_MAX_N       64
`define DCT_IDX_W       6
`define DCT_SIZE_W      7       // holds 0 .. 64

// cosine series
`define DCT_TERMS       5
`define DCT_PI_Q15      102943  // pi * 2**15, truncated

// register map
`define DCT_ADDR_START  0
`define DCT_ADDR_DATA   1
`define DCT_ADDR_SETQ   3

`define DCT_DEFAULT_M   5       // Q5.10 out of reset

`endif

//--- dct_pkg.sv
`default_nettype none

`include "dct_params.svh"

package dct_pkg;

    // fixed point word, Q(M).(15-M)
    typedef logic signed [`DCT_DATA_W-1:0] data_t;

    typedef logic [`DCT_IDX_W-1:0]  index_t;
    typedef logic [`DCT_SIZE_W-1:0] size_t;
    typedef logic [2:0]             qbits_t;    // integer bits M

    // folded angle, at most pi in the current format
    typedef logic [17:0] angle_t;

    typedef logic signed [`DCT_ACC_W-1:0] acc_t;

    typedef struct packed {
        index_t index;
        data_t  data;
    } sample_wr_t;

    typedef struct packed {
        index_t index;
        data_t  data;
    } result_wr_t;

    typedef struct packed {
        size_t  size;
        qbits_t int_bits;
    } dct_job_t;

    typedef enum logic [2:0] {
        IDLE,
        ANGLE,
        SERIES,
        ACCUM,
        POST
    } engine_state_e;

endpackage

`default_nettype wire

//--- dct_host_port.sv
`default_nettype none
`timescale 1ns/10ps

`include "dct_params.svh"

module dct_host_port (
    input  wire logic                   Clock,
    input  wire logic                   Reset,
    input  wire logic [`DCT_ADDR_W-1:0] address,
    input  wire logic                   read,
    input  wire logic                   write,
    input  wire dct_pkg::data_t         writedata,
    input  wire logic                   job_done,
    input  wire logic                   result_wr,
    input  wire dct_pkg::result_wr_t    result,
    output dct_pkg::data_t              readdata,
    output logic                        ready,
    output logic                        sample_wr,
    output dct_pkg::sample_wr_t         sample,
    output logic                        job_start,
    output logic                        job_abort,
    output dct_pkg::dct_job_t           job
);
    import dct_pkg::*;

    localparam logic [`DCT_ADDR_W-1:0] ADDR_START = `DCT_ADDR_START;
    localparam logic [`DCT_ADDR_W-1:0] ADDR_DATA  = `DCT_ADDR_DATA;
    localparam logic [`DCT_ADDR_W-1:0] ADDR_SETQ  = `DCT_ADDR_SETQ;

    data_t                 result_mem [`DCT_MAX_N];
    logic [`DCT_MAX_N-1:0] valid;       // one flag per coefficient
    qbits_t                m_q;         // pending M, used at next START
    size_t                 load_cnt;
    logic                  busy;        // engine owns the results

    logic   wr_start;
    logic   wr_data;
    logic   wr_setq;
    logic   load_ok;
    logic   in_range;
    size_t  new_size;
    index_t rd_idx;

    assign wr_start = write && (address == ADDR_START);
    assign wr_data  = write && (address == ADDR_DATA);
    assign wr_setq  = write && (address == ADDR_SETQ);

    // lengths past the buffer are clamped
    assign new_size = ($unsigned(writedata) > `DCT_MAX_N) ? size_t'(`DCT_MAX_N)
                                                          : writedata[`DCT_SIZE_W-1:0];

    assign load_ok = wr_data && (load_cnt < job.size);

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            job       <= '{size: '0, int_bits: qbits_t'(`DCT_DEFAULT_M)};
            m_q       <= qbits_t'(`DCT_DEFAULT_M);
            load_cnt  <= '0;
            valid     <= '0;
            busy      <= 1'b0;
            sample_wr <= 1'b0;
            job_start <= 1'b0;
            job_abort <= 1'b0;
        end else begin
            sample_wr <= load_ok;
            job_start <= load_ok && (load_cnt == job.size - size_t'(1)); // last sample
            job_abort <= wr_start;
            if (wr_setq) begin
                m_q <= writedata[2:0];
            end
            if (wr_start) begin
                job.size     <= new_size;
                job.int_bits <= m_q;
                load_cnt     <= '0;
                valid        <= '0;
                busy         <= 1'b0;
            end else begin
                if (load_ok) begin
                    load_cnt <= load_cnt + size_t'(1);
                end
                if (job_start) begin
                    busy <= 1'b1;
                end else if (job_done) begin
                    busy <= 1'b0;
                end
                if (result_wr && busy) begin
                    valid[result.index] <= 1'b1;
                end
            end
        end
    end

    // write payloads
    always_ff @(posedge Clock) begin
        sample <= '{index: load_cnt[`DCT_IDX_W-1:0], data: writedata};
        if (result_wr && busy) begin
            result_mem[result.index] <= result.data;
        end
    end

    // read-back, no cycles, stall only on a pending coefficient
    assign in_range = ({1'b0, job.size} > address);
    assign rd_idx   = address[`DCT_IDX_W-1:0];
    assign readdata = (read && in_range) ? result_mem[rd_idx] : '0;
    assign ready    = !read || !in_range || valid[rd_idx];

endmodule

`default_nettype wire

//--- dct_sample_ram.sv
`default_nettype none
`timescale 1ns/10ps

`include "dct_params.svh"

module dct_sample_ram (
    input  wire logic                Clock,
    input  wire logic                sample_wr,
    input  wire dct_pkg::sample_wr_t sample,
    input  wire dct_pkg::index_t     rd_index,
    output dct_pkg::data_t           rd_data
);
    import dct_pkg::*;

    data_t mem [`DCT_MAX_N];

    // host side loads one sample per strobe
    always_ff @(posedge Clock) begin
        if (sample_wr) begin
            mem[sample.index] <= sample.data;
        end
    end

    // engine side, registered read
    always_ff @(posedge Clock) begin
        rd_data <= mem[rd_index];
    end

endmodule

`default_nettype wire

//--- cos_series.sv
`default_nettype none
`timescale 1ns/10ps

`include "dct_params.svh"

// Taylor cosine for 0 <= x <= pi, one term per clock
module cos_series (
    input  wire logic            Clock,
    input  wire logic            Reset,
    input  wire logic            start,
    input  wire dct_pkg::angle_t x,
    input  wire dct_pkg::qbits_t frac_bits,  // fraction bits minus 8
    output logic                 done,
    output dct_pkg::data_t       result
);
    import dct_pkg::*;

    localparam int TERMS  = `DCT_TERMS;
    localparam int PROD_W = 2 * `DCT_ACC_W;

    logic [2:0] term_i;     // 0 when idle
    acc_t       value;
    acc_t       power;
    acc_t       denom;
    acc_t       x2;

    logic [3:0]                   frac;
    logic [2*$bits(angle_t)-1:0]  x_sq;
    logic signed [PROD_W-1:0]     pow_prod;
    logic                         stepping;
    acc_t                         two_i;
    acc_t                         next_power;
    acc_t                         next_denom;
    acc_t                         term;
    acc_t                         next_value;

    assign frac     = 4'd8 + {1'b0, frac_bits};
    assign x_sq     = x * x;
    assign stepping = (term_i != '0) && (term_i < 3'(TERMS - 1));

    always_comb begin
        two_i      = acc_t'({term_i, 1'b0});
        pow_prod   = PROD_W'(power) * PROD_W'(x2);
        next_power = acc_t'(pow_prod >>> frac);
        next_denom = denom * two_i * (two_i - acc_t'(1));   // (2i)!
        term       = (next_denom != '0) ? next_power / next_denom : '0;
        next_value = term_i[0] ? value - term : value + term;   // odd terms subtract
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            term_i <= '0;
        end else if (start) begin
            term_i <= 3'd1;
        end else if (stepping) begin
            term_i <= term_i + 3'd1;
        end
    end

    always_ff @(posedge Clock) begin
        if (start) begin
            value <= acc_t'(1) << frac;
            power <= acc_t'(1) << frac;
            denom <= acc_t'(1);
            x2    <= acc_t'(x_sq >> frac);
        end else if (stepping) begin
            value <= next_value;
            power <= next_power;
            denom <= next_denom;
        end
    end

    // last term is folded in combinationally while the counter rests
    assign done   = (term_i == 3'(TERMS - 1));
    assign result = data_t'(next_value);

endmodule

`default_nettype wire

//--- dct_engine.sv
`default_nettype none
`timescale 1ns/10ps

`include "dct_params.svh"

module dct_engine (
    input  wire logic              Clock,
    input  wire logic              Reset,
    input  wire logic              job_start,
    input  wire logic              job_abort,
    input  wire dct_pkg::dct_job_t job,
    input  wire dct_pkg::data_t    rd_data,
    output dct_pkg::index_t        rd_index,
    output logic                   result_wr,
    output dct_pkg::result_wr_t    result
);
    import dct_pkg::*;

    engine_state_e state;
    index_t        k_idx;
    index_t        n_idx;
    acc_t          acc;

    acc_t       pi_q;
    acc_t       two_pi_q;
    acc_t       step;
    acc_t       raw_angle;
    acc_t       folded;
    acc_t       product;
    logic [3:0] frac;
    qbits_t     cos_frac;
    logic       last_n;
    logic       last_k;
    logic       cos_start;
    logic       cos_done;
    data_t      cos_val;

    // angle for (k, n), brought back into 0 .. pi
    always_comb begin
        pi_q      = acc_t'(`DCT_PI_Q15) >> job.int_bits;
        two_pi_q  = pi_q << 1;
        step      = pi_q / ((job.size == '0) ? acc_t'(1) : acc_t'(job.size));
        raw_angle = ((step * acc_t'({n_idx, 1'b1}) * acc_t'(k_idx)) >> 1) % two_pi_q;
        folded    = (raw_angle > pi_q) ? two_pi_q - raw_angle : raw_angle;
    end

    assign frac     = 4'd15 - {1'b0, job.int_bits};
    assign cos_frac = 3'd7 - job.int_bits;
    assign product  = acc_t'(cos_val) * acc_t'(rd_data);

    assign last_n = ({1'b0, n_idx} == job.size - size_t'(1));
    assign last_k = ({1'b0, k_idx} == job.size - size_t'(1));

    assign cos_start = (state == ANGLE);
    assign rd_index  = n_idx;           // sample is ready well before ACCUM

    cos_series u_cos_series (
        .Clock     (Clock),
        .Reset     (Reset),
        .start     (cos_start),
        .x         (angle_t'(folded)),
        .frac_bits (cos_frac),
        .done      (cos_done),
        .result    (cos_val)
    );

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            state <= IDLE;
            k_idx <= '0;
            n_idx <= '0;
            acc   <= '0;
        end else if (job_abort) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (job_start) begin
                        state <= ANGLE;
                        k_idx <= '0;
                        n_idx <= '0;
                        acc   <= '0;
                    end
                end
                ANGLE: begin
                    state <= SERIES;
                end
                SERIES: begin
                    if (cos_done) begin
                        state <= ACCUM;
                    end
                end
                ACCUM: begin
                    acc <= acc + (product >>> frac);
                    if (last_n) begin
                        state <= POST;
                    end else begin
                        n_idx <= n_idx + index_t'(1);
                        state <= ANGLE;
                    end
                end
                POST: begin
                    k_idx <= k_idx + index_t'(1);
                    n_idx <= '0;
                    acc   <= '0;
                    state <= last_k ? IDLE : ANGLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // abort in the same cycle drops the post
    assign result_wr = (state == POST) && !job_abort;
    assign result    = '{index: k_idx, data: data_t'(acc)};

endmodule

`default_nettype wire

//--- avalon_dct.sv
`default_nettype none
`timescale 1ns/10ps

`include "dct_params.svh"

module avalon_dct (
    input  wire logic                   Clock,
    input  wire logic                   Reset,
    input  wire logic [`DCT_ADDR_W-1:0] address,
    input  wire logic                   read,
    input  wire logic                   write,
    input  wire dct_pkg::data_t         writedata,
    output dct_pkg::data_t              readdata,
    output logic                        ready
);
    import dct_pkg::*;

    logic       sample_wr;
    sample_wr_t sample;
    index_t     rd_index;
    data_t      rd_data;
    logic       job_start;
    logic       job_abort;
    dct_job_t   job;
    logic       job_done;
    logic       result_wr;
    result_wr_t result;

    // the last coefficient of the job is being posted
    assign job_done = result_wr && ({1'b0, result.index} == job.size - size_t'(1));

    dct_host_port u_host_port (
        .Clock     (Clock),
        .Reset     (Reset),
        .address   (address),
        .read      (read),
        .write     (write),
        .writedata (writedata),
        .job_done  (job_done),
        .result_wr (result_wr),
        .result    (result),
        .readdata  (readdata),
        .ready     (ready),
        .sample_wr (sample_wr),
        .sample    (sample),
        .job_start (job_start),
        .job_abort (job_abort),
        .job       (job)
    );

    dct_sample_ram u_sample_ram (
        .Clock     (Clock),
        .sample_wr (sample_wr),
        .sample    (sample),
        .rd_index  (rd_index),
        .rd_data   (rd_data)
    );

    dct_engine u_engine (
        .Clock     (Clock),
        .Reset     (Reset),
        .job_start (job_start),
        .job_abort (job_abort),
        .job       (job),
        .rd_data   (rd_data),
        .rd_index  (rd_index),
        .result_wr (result_wr),
        .result    (result)
    );

endmodule

`default_nettype wire

//--- avalon_dct_sva.sv
`default_nettype none
`timescale 1ns/10ps

module avalon_dct_sva (
    input wire logic                Clock,
    input wire logic                Reset,
    input wire logic                read,
    input wire logic                ready,
    input wire logic                job_start,
    input wire logic                job_abort,
    input wire logic                result_wr,
    input wire dct_pkg::result_wr_t result,
    input wire dct_pkg::dct_job_t   job
);

    int fail_count = 0;     // read by the testbench at the end

    // only a pending read may stall the bus
    ready_without_read: assert property (@(posedge Clock) disable iff (Reset)
        !read |-> ready)
        else begin
            $error("ready low while read is low");
            fail_count++;
        end

    posted_index_in_range: assert property (@(posedge Clock) disable iff (Reset)
        result_wr |-> ({1'b0, result.index} < job.size))
        else begin
            $error("coefficient index %0d not below length %0d", result.index, job.size);
            fail_count++;
        end

    start_abort_exclusive: assert property (@(posedge Clock) disable iff (Reset)
        !(job_start && job_abort))
        else begin
            $error("job_start and job_abort high together");
            fail_count++;
        end

endmodule

bind avalon_dct avalon_dct_sva u_avalon_dct_sva (
    .Clock     (Clock),
    .Reset     (Reset),
    .read      (read),
    .ready     (ready),
    .job_start (job_start),
    .job_abort (job_abort),
    .result_wr (result_wr),
    .result    (result),
    .job       (job)
);

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic Clock,
    output logic Reset
);

    initial begin
        Clock = 1'b0;
        forever #(PERIOD / 2) Clock = ~Clock;
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        Reset = 1'b1;
        #(PERIOD * RESET_CYCLES);
        Reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- tb_avalon_dct.sv
`default_nettype none
`timescale 1ns/10ps

`include "dct_params.svh"

module tb_avalon_dct;
    import dct_pkg::*;

    typedef logic [`DCT_ADDR_W-1:0] addr_t;

    localparam int READ_TIMEOUT  = 30000;   // a full 64 point job is about 25k cycles
    localparam int RESET_TIMEOUT = 100;

    logic  Clock;
    logic  Reset;
    addr_t address;
    logic  read;
    logic  write;
    data_t writedata;
    data_t readdata;
    logic  ready;

    logic [31:0] lcg_state = 32'd32735;
    int          samples [`DCT_MAX_N];
    int          cur_size;      // length of the job the host holds
    int          cur_m;         // M of that job
    int          pending_m;     // last SETQ value

    tb_clock_gen u_clock_gen (
        .Clock (Clock),
        .Reset (Reset)
    );

    avalon_dct u_avalon_dct (
        .Clock     (Clock),
        .Reset     (Reset),
        .address   (address),
        .read      (read),
        .write     (write),
        .writedata (writedata),
        .readdata  (readdata),
        .ready     (ready)
    );

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:8]);   // low bits of an LCG are weak
    endfunction

    function automatic int rand_range(int lo, int hi);
        return lo + next_rand() % (hi - lo + 1);
    endfunction

    // truncated Taylor series in Q(15-f), one term at a time
    function automatic data_t model_cos(longint x, int f);
        int value;
        int power;
        int denom;
        int term;
        int x2;
        int i;
        value = 1 << f;
        power = 1 << f;
        denom = 1;
        x2    = int'((x * x) >> f);
        for (i = 1; i < `DCT_TERMS; i++) begin
            power = int'((longint'(power) * longint'(x2)) >>> f);
            denom = denom * (2 * i) * (2 * i - 1);
            term  = power / denom;
            if (i % 2 == 1) begin
                value = value - term;
            end else begin
                value = value + term;
            end
        end
        return data_t'(value);
    endfunction

    function automatic data_t model_coef(int size, int m, int k);
        int     f;
        int     acc;
        int     n;
        longint pi_q;
        longint step;
        longint angle;
        data_t  c;
        f    = 15 - m;
        pi_q = longint'(`DCT_PI_Q15) >> m;
        step = pi_q / size;
        acc  = 0;
        for (n = 0; n < size; n++) begin
            angle = ((step * (2 * n + 1) * k) >> 1) % (2 * pi_q);
            if (angle > pi_q) begin
                angle = 2 * pi_q - angle;   // fold back into 0 .. pi
            end
            c   = model_cos(angle, f);
            acc = acc + ((int'(c) * samples[n]) >>> f);
        end
        return data_t'(acc);
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_data(input string name, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("error: %s is %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_ready(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            fail_run($sformatf("error: %s is %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic write_reg(input addr_t addr, input data_t data);
        @(negedge Clock);
        address   = addr;
        writedata = data;
        write     = 1'b1;
        @(negedge Clock);
        write     = 1'b0;
    endtask

    // holds read until ready, first_ready is ready in the first cycle
    task automatic read_reg(input addr_t addr, output data_t data, output logic first_ready);
        int waited;
        @(negedge Clock);
        address = addr;
        read    = 1'b1;
        #1;
        first_ready = ready;
        waited      = 0;
        while (ready !== 1'b1) begin
            if (waited >= READ_TIMEOUT) begin
                fail_run($sformatf("read of address %0d got no ready in %0d cycles",
                                   addr, READ_TIMEOUT));
            end
            @(negedge Clock);
            #1;
            waited++;
        end
        data = readdata;
        @(negedge Clock);
        read = 1'b0;
    endtask

    task automatic set_q(input int m);
        write_reg(addr_t'(`DCT_ADDR_SETQ), data_t'(m));
        pending_m = m;
    endtask

    task automatic start_job(input int size);
        write_reg(addr_t'(`DCT_ADDR_START), data_t'(size));
        cur_size = size;
        cur_m    = pending_m;
    endtask

    task automatic load_samples();
        int n;
        for (n = 0; n < cur_size; n++) begin
            samples[n] = rand_range(-8192, 8191);   // quarter of full scale
            write_reg(addr_t'(`DCT_ADDR_DATA), data_t'(samples[n]));
        end
    endtask

    task automatic check_zero_read(input int addr);
        data_t rd;
        logic  rdy;
        read_reg(addr_t'(addr), rd, rdy);
        check_ready($sformatf("ready at address %0d", addr), rdy, 1'b1);
        check_data($sformatf("readdata at address %0d", addr), rd, '0);
    endtask

    task automatic check_out_of_range();
        check_zero_read(cur_size);
        check_zero_read(rand_range(cur_size, 255));
        check_zero_read(255);
    endtask

    task automatic check_coefs();
        data_t rd;
        logic  rdy;
        int    k;
        for (k = 0; k < cur_size; k++) begin
            read_reg(addr_t'(k), rd, rdy);
            check_data($sformatf("readdata[%0d]", k), rd, model_coef(cur_size, cur_m, k));
        end
    endtask

    task automatic run_job(input int size);
        start_job(size);
        check_out_of_range();
        load_samples();
        check_out_of_range();   // engine busy here
        check_coefs();
        check_out_of_range();
    endtask

    initial begin
        data_t rd;
        logic  rdy;
        int    waited;
        int    i;
        address   = '0;
        read      = 1'b0;
        write     = 1'b0;
        writedata = '0;
        cur_size  = 0;
        cur_m     = `DCT_DEFAULT_M;
        pending_m = `DCT_DEFAULT_M;

        waited = 0;
        while (Reset !== 1'b0) begin
            if (waited >= RESET_TIMEOUT) begin
                fail_run("reset was never released");
            end
            @(negedge Clock);
            waited++;
        end

        // length is zero out of reset, so every address reads as zero
        for (i = 0; i < 4; i++) begin
            check_zero_read(i);
        end
        check_out_of_range();

        for (i = 0; i < 6; i++) begin
            run_job(rand_range(1, `DCT_MAX_N));
        end

        for (i = 0; i < 2; i++) begin
            set_q(rand_range(0, 7));
            run_job(rand_range(1, `DCT_MAX_N));
        end

        // abort while k = 1 is being computed
        start_job(rand_range(16, `DCT_MAX_N));
        load_samples();
        read_reg(addr_t'(0), rd, rdy);
        check_data("readdata[0]", rd, model_coef(cur_size, cur_m, 0));
        start_job(rand_range(1, `DCT_MAX_N));
        check_out_of_range();
        load_samples();
        check_coefs();

        // last coefficient asked for right after the last sample
        set_q(rand_range(0, 7));
        start_job(rand_range(8, `DCT_MAX_N));
        load_samples();
        read_reg(addr_t'(cur_size - 1), rd, rdy);
        check_ready("ready", rdy, 1'b0);
        check_data($sformatf("readdata[%0d]", cur_size - 1), rd,
                   model_coef(cur_size, cur_m, cur_size - 1));
        check_coefs();

        if (u_avalon_dct.u_avalon_dct_sva.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            fail_run($sformatf("%0d assertion failures",
                               u_avalon_dct.u_avalon_dct_sva.fail_count));
        end
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
dct_pkg.sv
dct_host_port.sv
dct_sample_ram.sv
cos_series.sv
dct_engine.sv
avalon_dct.sv
avalon_dct_sva.sv
tb_clock_gen.sv
tb_avalon_dct.sv

//--- Makefile
# Verilator build and run for the DCT peripheral testbench

VERILATOR ?= verilator
FILELIST  ?= compile.f
TOP       ?= tb_avalon_dct
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ALL TESTS PASSED

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard *.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
